/* include/fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// first address fetched out of reset
`define FETCH_RESET_PC 32'h0000_0000

// direct-mapped, one word per line
`define FETCH_LINES 16

// line select, word aligned
`define FETCH_INDEX_LSB 2
`define FETCH_INDEX_MSB 5

// stored tag, covers the low 256 KB only
`define FETCH_TAG_LSB 6
`define FETCH_TAG_MSB 17

`endif

/* verilog/fetch_pkg.sv */
`include "fetch_params.svh"

package fetch_pkg;

    // byte address and instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // widths follow the address split
    typedef logic [`FETCH_INDEX_MSB-`FETCH_INDEX_LSB:0] index_t;
    typedef logic [`FETCH_TAG_MSB-`FETCH_TAG_LSB:0] tag_t;

    typedef enum logic [1:0]
    {
        IDLE,
        LOOKUP,
        MISS_REQ,
        REFILL
    } icache_state_t;

endpackage

/* verilog/icache_store.sv */
`include "fetch_params.svh"

module icache_store (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  fetch_pkg::index_t lookup_index,
    input  fetch_pkg::tag_t  lookup_tag,
    output logic             hit,
    output fetch_pkg::word_t hit_data,
    input  logic             fill_en,
    input  fetch_pkg::word_t fill_data
);

    logic [`FETCH_LINES-1:0] valid_q;
    fetch_pkg::tag_t         tag_q  [`FETCH_LINES];
    fetch_pkg::word_t        data_q [`FETCH_LINES];

    // a fill in the flush cycle still lands
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= '0;
        end
        else
        begin
            if (flush)
            begin
                valid_q <= '0;
            end
            if (fill_en)
            begin
                valid_q[lookup_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            tag_q[lookup_index]  <= lookup_tag;
            data_q[lookup_index] <= fill_data;
        end
    end

    assign hit      = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
    assign hit_data = data_q[lookup_index];

    // nothing survives a flush unless refilled in the same cycle
    a_flush_clears: assert property (@(posedge clk) disable iff (rst)
        (flush && !fill_en) |=> !hit);

endmodule

/* verilog/icache_ctrl.sv */
`include "fetch_params.svh"

module icache_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_req,
    input  fetch_pkg::addr_t  fetch_addr,
    output logic              cache_idle,
    output logic              resp_valid,
    output fetch_pkg::word_t  resp_data,
    output fetch_pkg::index_t lookup_index,
    output fetch_pkg::tag_t   lookup_tag,
    input  logic              hit,
    input  fetch_pkg::word_t  hit_data,
    output logic              fill_en,
    output fetch_pkg::word_t  fill_data,
    output logic              mem_req_valid,
    output fetch_pkg::addr_t  mem_req_addr,
    input  fetch_pkg::word_t  mem_req_data,
    input  logic              mem_req_ready
);

    fetch_pkg::icache_state_t state_q;
    fetch_pkg::addr_t         req_addr_q;
    fetch_pkg::word_t         refill_word_q;
    fetch_pkg::word_t         resp_data_q;
    fetch_pkg::addr_t         mem_addr_q;
    logic                     resp_valid_q;
    logic                     mem_valid_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q      <= fetch_pkg::IDLE;
            resp_valid_q <= 1'b0;
            mem_valid_q  <= 1'b0;
        end
        else
        begin
            resp_valid_q <= 1'b0;
            case (state_q)
                fetch_pkg::IDLE:
                begin
                    if (fetch_req)
                    begin
                        state_q <= fetch_pkg::LOOKUP;
                    end
                end
                fetch_pkg::LOOKUP:
                begin
                    if (hit)
                    begin
                        resp_valid_q <= 1'b1;
                        state_q      <= fetch_pkg::IDLE;
                    end
                    else
                    begin
                        mem_valid_q <= 1'b1;
                        state_q     <= fetch_pkg::MISS_REQ;
                    end
                end
                fetch_pkg::MISS_REQ:
                begin
                    // memory may stall here indefinitely
                    if (mem_req_ready)
                    begin
                        mem_valid_q <= 1'b0;
                        state_q     <= fetch_pkg::REFILL;
                    end
                end
                fetch_pkg::REFILL:
                begin
                    resp_valid_q <= 1'b1;
                    state_q      <= fetch_pkg::IDLE;
                end
                default:
                begin
                    state_q <= fetch_pkg::IDLE;
                end
            endcase
        end
    end

    // address, request and response payload
    always_ff @(posedge clk)
    begin
        if (state_q == fetch_pkg::IDLE && fetch_req)
        begin
            req_addr_q <= fetch_addr;
        end
        if (state_q == fetch_pkg::LOOKUP)
        begin
            resp_data_q <= hit_data;
            mem_addr_q  <= {req_addr_q[31:2], 2'b00};
        end
        if (state_q == fetch_pkg::MISS_REQ && mem_req_ready)
        begin
            refill_word_q <= mem_req_data;
        end
        if (state_q == fetch_pkg::REFILL)
        begin
            resp_data_q <= refill_word_q;
        end
    end

    assign cache_idle    = (state_q == fetch_pkg::IDLE);
    assign lookup_index  = req_addr_q[`FETCH_INDEX_MSB:`FETCH_INDEX_LSB];
    assign lookup_tag    = req_addr_q[`FETCH_TAG_MSB:`FETCH_TAG_LSB];
    assign fill_en       = (state_q == fetch_pkg::REFILL);
    assign fill_data     = refill_word_q;
    assign resp_valid    = resp_valid_q;
    assign resp_data     = resp_data_q;
    assign mem_req_valid = mem_valid_q;
    assign mem_req_addr  = mem_addr_q;

    a_mem_req_hold: assert property (@(posedge clk) disable iff (rst)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req_addr)));

    a_resp_single: assert property (@(posedge clk) disable iff (rst)
        resp_valid |=> !resp_valid);

    // a fill always follows an accepted memory read
    a_fill_in_refill: assert property (@(posedge clk) disable iff (rst)
        fill_en |-> (state_q == fetch_pkg::REFILL) && $past(mem_req_valid && mem_req_ready));

endmodule

/* verilog/fetch_pc.sv */
`include "fetch_params.svh"

module fetch_pc (
    input  logic             clk,
    input  logic             rst,
    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_pc,
    output logic             fetch_req,
    output fetch_pkg::addr_t fetch_addr,
    input  logic             cache_idle,
    input  logic             resp_valid,
    input  fetch_pkg::word_t resp_data,
    output logic             inst_valid,
    output fetch_pkg::addr_t inst_pc,
    output fetch_pkg::word_t inst_data
);

    fetch_pkg::addr_t pc_q;
    logic             req_q;
    logic             busy_q;
    logic             discard_q;
    logic             accept;
    logic             deliver;

    assign accept  = req_q && cache_idle;
    // a redirect in the response cycle also drops the word
    assign deliver = resp_valid && !discard_q && !redirect;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc_q       <= `FETCH_RESET_PC;
            req_q      <= 1'b0;
            busy_q     <= 1'b0;
            discard_q  <= 1'b0;
            inst_valid <= 1'b0;
        end
        else
        begin
            if (redirect)
            begin
                pc_q <= redirect_pc;
            end
            else if (deliver)
            begin
                pc_q <= pc_q + 32'd4;
            end
            if (accept)
            begin
                req_q  <= 1'b0;
                busy_q <= 1'b1;
            end
            else if (resp_valid || (!busy_q && !req_q))
            begin
                req_q  <= 1'b1;
                busy_q <= 1'b0;
            end
            if (resp_valid)
            begin
                discard_q <= 1'b0;
            end
            else if (redirect && (busy_q || accept))
            begin
                discard_q <= 1'b1;
            end
            inst_valid <= deliver;
        end
    end

    always_ff @(posedge clk)
    begin
        if (deliver)
        begin
            inst_pc   <= pc_q;
            inst_data <= resp_data;
        end
    end

    assign fetch_req  = req_q;
    assign fetch_addr = pc_q;

endmodule

/* verilog/fetch_stage.sv */
module fetch_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             flush,
    output logic             inst_valid,
    output fetch_pkg::addr_t inst_pc,
    output fetch_pkg::word_t inst_data,
    output logic             mem_req_valid,
    output fetch_pkg::addr_t mem_req_addr,
    input  fetch_pkg::word_t mem_req_data,
    input  logic             mem_req_ready
);

    logic              fetch_req;
    fetch_pkg::addr_t  fetch_addr;
    logic              cache_idle;
    logic              resp_valid;
    fetch_pkg::word_t  resp_data;
    fetch_pkg::index_t lookup_index;
    fetch_pkg::tag_t   lookup_tag;
    logic              hit;
    fetch_pkg::word_t  hit_data;
    logic              fill_en;
    fetch_pkg::word_t  fill_data;

    fetch_pc fetch_pc_i (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .cache_idle  (cache_idle),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .inst_valid  (inst_valid),
        .inst_pc     (inst_pc),
        .inst_data   (inst_data)
    );

    icache_ctrl icache_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .fetch_req     (fetch_req),
        .fetch_addr    (fetch_addr),
        .cache_idle    (cache_idle),
        .resp_valid    (resp_valid),
        .resp_data     (resp_data),
        .lookup_index  (lookup_index),
        .lookup_tag    (lookup_tag),
        .hit           (hit),
        .hit_data      (hit_data),
        .fill_en       (fill_en),
        .fill_data     (fill_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready)
    );

    // flush bypasses the controller
    icache_store icache_store_i (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .hit_data     (hit_data),
        .fill_en      (fill_en),
        .fill_data    (fill_data)
    );

endmodule

/* verif/fetch_stage_tb.sv */
`include "fetch_params.svh"

module fetch_stage_tb;

    logic             clk;
    logic             rst;
    logic             redirect;
    fetch_pkg::addr_t redirect_pc;
    logic             flush;
    logic             inst_valid;
    fetch_pkg::addr_t inst_pc;
    fetch_pkg::word_t inst_data;
    logic             mem_req_valid;
    fetch_pkg::addr_t mem_req_addr;
    fetch_pkg::word_t mem_req_data;
    logic             mem_req_ready;

    fetch_pkg::word_t mem    [0:1023];
    logic [31:0]      script [0:127];
    fetch_pkg::addr_t exp_pc;
    fetch_pkg::addr_t stale_pc;
    logic             redirect_open;
    int               seed;
    int               wait_cnt;
    int               limit_cycles;
    int               seg_insts;
    int               seg_reqs;
    logic             req_level;
    int               check_count;
    int               error_count;

    fetch_stage fetch_stage_i (
        .clk           (clk),
        .rst           (rst),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .flush         (flush),
        .inst_valid    (inst_valid),
        .inst_pc       (inst_pc),
        .inst_data     (inst_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    // runs one script record from a rising edge
    task run_segment(input logic [31:0] kind, input logic [31:0] target,
                     input logic [31:0] n_insts, input logic [31:0] n_reqs);
        seg_reqs  = 0;
        seg_insts = 0;
        if (kind == 5)
        begin
            // hold the redirect until a miss is out on the bus
            while (!req_level)
            begin
                @(posedge clk);
            end
        end
        if (kind >= 3)
        begin
            redirect    <= 1'b1;
            redirect_pc <= target;
            flush       <= (kind == 4);
        end
        @(posedge clk);
        redirect <= 1'b0;
        flush    <= 1'b0;
        while (seg_insts < n_insts)
        begin
            @(posedge clk);
        end
        check_value("mem request count", seg_reqs, n_reqs);
    endtask

    // memory model answers after 0 to 3 idle cycles
    always @(posedge clk)
    begin
        mem_req_ready <= 1'b0;
        if (!rst && mem_req_valid && !mem_req_ready)
        begin
            if (wait_cnt == 0)
            begin
                mem_req_ready <= 1'b1;
                mem_req_data  <= mem[mem_req_addr[11:2]];
                wait_cnt      <= $unsigned($random(seed)) % 4;
            end
            else
            begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    // scoreboard samples on the falling edge
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (mem_req_valid && !req_level)
            begin
                seg_reqs++;
                // the abandoned fetch may still go out at the old address
                if (!redirect_open || mem_req_addr !== stale_pc)
                begin
                    check_value("mem_req_addr", mem_req_addr, exp_pc);
                end
            end
            req_level = mem_req_valid;
            if (inst_valid)
            begin
                check_value("inst_pc", inst_pc, exp_pc);
                check_value("inst_data", inst_data, mem[exp_pc[11:2]]);
                exp_pc = exp_pc + 32'd4;
                seg_insts++;
                redirect_open = 1'b0;
            end
            // older words still count against the old stream
            if (redirect)
            begin
                stale_pc      = exp_pc;
                redirect_open = 1'b1;
                exp_pc        = redirect_pc;
            end
        end
    end

    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        error_count++;
        $display("watchdog expired after %0d cycles, the fetch stream stalled", limit_cycles);
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        int i;
        int rec;
        int total;
        clk           = 1'b0;
        rst           = 1'b1;
        redirect      = 1'b0;
        redirect_pc   = '0;
        flush         = 1'b0;
        mem_req_ready = 1'b0;
        mem_req_data  = '0;
        req_level     = 1'b0;
        redirect_open = 1'b0;
        stale_pc      = '0;
        check_count   = 0;
        error_count   = 0;
        limit_cycles  = 0;
        exp_pc        = `FETCH_RESET_PC;
        seed          = 52458;
        wait_cnt      = $unsigned($random(seed)) % 4;
        for (i = 0; i < 1024; i++)
        begin
            mem[i] = (i << 18) ^ (i << 2) ^ 32'h5A3C_0F00;
        end
        for (i = 0; i < 128; i++)
        begin
            script[i] = '0;
        end
        $readmemh("verif/fetch_input.txt", script);
        total = 0;
        for (rec = 0; script[rec * 4] != 0; rec++)
        begin
            if (script[rec * 4] == 1)
            begin
                mem[script[rec * 4 + 1][11:2]] = script[rec * 4 + 2];
            end
            else
            begin
                total += script[rec * 4 + 2];
            end
        end
        limit_cycles = total * 20 + 10;

        // reset spans ten rising edges, the last one below
        repeat (9)
        begin
            @(negedge clk);
            check_value("inst_valid", inst_valid, 1'b0);
            check_value("mem_req_valid", mem_req_valid, 1'b0);
        end
        @(posedge clk);
        rst <= 1'b0;
        // first cycle out of reset
        @(negedge clk);
        check_value("inst_valid", inst_valid, 1'b0);
        check_value("mem_req_valid", mem_req_valid, 1'b0);
        @(posedge clk);

        for (rec = 0; script[rec * 4] != 0; rec++)
        begin
            if (script[rec * 4] != 1)
            begin
                run_segment(script[rec * 4], script[rec * 4 + 1],
                            script[rec * 4 + 2], script[rec * 4 + 3]);
            end
        end

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* verif/fetch_input.txt */
// columns: kind address value requests, kind 1 memory word (value is the word),
// 2 run on, 3 redirect, 4 flush and redirect, 5 redirect during a miss, 0 ends
1 00000000 00000013 00000000
1 00000004 00100093 00000000
1 00000008 00208113 00000000
1 0000000c 00310193 00000000
1 00000040 0000006f 00000000
1 00000100 fe000ee3 00000000
// cold stream from reset
2 00000000 00000008 00000008
// back into the loop, first one also sees the abandoned refill of 0x20
3 00000000 00000008 00000001
3 00000000 00000008 00000000
4 00000000 00000008 00000008
// same index, other tag
3 00000040 00000001 00000002
3 00000000 00000001 00000002
5 00000100 00000004 00000005
5 00000200 00000002 00000003
0 00000000 00000000 00000000

/* filelist.f */
+incdir+include
verilog/fetch_pkg.sv
verilog/icache_store.sv
verilog/icache_ctrl.sv
verilog/fetch_pc.sv
verilog/fetch_stage.sv
verif/fetch_stage_tb.sv

/* Bender.yml */
package:
  name: fetch_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/fetch_pkg.sv
      - verilog/icache_store.sv
      - verilog/icache_ctrl.sv
      - verilog/fetch_pc.sv
      - verilog/fetch_stage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/fetch_stage_tb.sv
